//--- include/cu_consts.svh
// Copy compute unit constants
// Bus widths, cache line geometry and data queue depth

`ifndef CU_CONSTS_SVH
`define CU_CONSTS_SVH

// Byte address width
`define CU_ADDR_BITS 64

// Line count and line index width
`define CU_COUNT_BITS 32

// One data word per cache line
`define CU_DATA_BITS 64

// Line i of an array sits at base + i * CU_LINE_BYTES
`define CU_LINE_BYTES 128

// Configure, status and return words
`define CU_CONFIG_BITS 64

// Data queue entries, also the read credit limit
`define CU_QUEUE_DEPTH 8

`endif

//--- source/cu_pkg.sv
// Copy compute unit types
// Descriptor, command, data and response lines plus opcode and state enums

`include "cu_consts.svh"

package cu_pkg;

	// Command opcodes
	typedef enum logic [1:0] {
		CMD_INVALID = 2'd0,
		CMD_READ    = 2'd1,
		CMD_WRITE   = 2'd2
	} cu_command_e;

	// Engine sequencing
	typedef enum logic [1:0] {
		ENG_IDLE  = 2'd0,
		ENG_ISSUE = 2'd1,
		ENG_DONE  = 2'd2
	} cu_engine_state_e;

	// Work descriptor, 193 bits
	typedef struct packed {
		logic                      valid;
		logic [`CU_ADDR_BITS-1:0]  array_send;
		logic [`CU_COUNT_BITS-1:0] size_send;
		logic [`CU_ADDR_BITS-1:0]  array_receive;
		logic [`CU_COUNT_BITS-1:0] size_receive;
	} cu_wed_t;

	// Command line, tag is the line index
	typedef struct packed {
		logic                      valid;
		cu_command_e               command;
		logic [`CU_ADDR_BITS-1:0]  address;
		logic [`CU_COUNT_BITS-1:0] tag;
		logic [`CU_DATA_BITS-1:0]  data;
	} cu_command_t;

	// Read data coming back, tagged with its line index
	typedef struct packed {
		logic                      valid;
		logic [`CU_COUNT_BITS-1:0] tag;
		logic [`CU_DATA_BITS-1:0]  data;
	} cu_data_line_t;

	typedef struct packed {
		logic                      valid;
		logic [`CU_COUNT_BITS-1:0] tag;
	} cu_response_t;

	// Address of one line inside an array
	function automatic logic [`CU_ADDR_BITS-1:0] line_address(
		input logic [`CU_ADDR_BITS-1:0]  base,
		input logic [`CU_COUNT_BITS-1:0] index
	);
		return base + (`CU_ADDR_BITS'(index) * `CU_ADDR_BITS'(`CU_LINE_BYTES));
	endfunction

endpackage

//--- source/cu_job_control.sv
// Job control for the copy compute unit
// Registers the enable, latches the inputs, holds the configure word
// and reports ready, done, status and return

`include "cu_consts.svh"

module cu_job_control (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled_in,
	input  cu_pkg::cu_wed_t            wed_request_in,
	input  logic [`CU_CONFIG_BITS-1:0] configure,
	input  cu_pkg::cu_data_line_t      read_data_in,
	input  cu_pkg::cu_response_t       write_response_in,
	input  logic [`CU_COUNT_BITS-1:0]  read_count,
	input  logic [`CU_COUNT_BITS-1:0]  write_count,
	output cu_pkg::cu_wed_t            wed_latched,
	output cu_pkg::cu_data_line_t      read_data_latched,
	output cu_pkg::cu_response_t       write_response_latched,
	output logic                       enabled,
	output logic                       engine_enable,
	output logic [`CU_CONFIG_BITS-1:0] cu_return,
	output logic [`CU_CONFIG_BITS-1:0] cu_status,
	output logic                       cu_done
);

	logic [`CU_CONFIG_BITS-1:0] configure_held;
	logic [`CU_CONFIG_BITS-1:0] return_next;
	logic                       ready;
	logic                       done_algorithm;

	////////////////////
	// Enable
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled       <= 1'b0;
			engine_enable <= 1'b0;
		end else begin
			enabled <= enabled_in;
			if (enabled) begin
				engine_enable <= ready;
			end
		end
	end

	////////////////////
	// Input latching
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_latched            <= '0;
			read_data_latched      <= '0;
			write_response_latched <= '0;
			configure_held         <= '0;
		end else if (enabled) begin
			wed_latched            <= wed_request_in;
			read_data_latched      <= read_data_in;
			write_response_latched <= write_response_in;
			// Configure sticks once it turns nonzero
			if (|configure) begin
				configure_held <= configure;
			end
		end else begin
			// Strobes must not repeat while frozen
			read_data_latched.valid      <= 1'b0;
			write_response_latched.valid <= 1'b0;
		end
	end

	////////////////////
	// Ready and done
	////////////////////

	assign ready = (|configure_held) && wed_latched.valid;

	assign done_algorithm = wed_latched.valid &&
		(wed_latched.size_send == read_count) &&
		(wed_latched.size_receive == write_count);

	assign return_next = wed_latched.valid ? `CU_CONFIG_BITS'(write_count) : '0;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_return <= '0;
			cu_status <= '0;
			cu_done   <= 1'b0;
		end else if (enabled) begin
			cu_return <= return_next;
			cu_status <= `CU_CONFIG_BITS'(ready);
			cu_done   <= done_algorithm;
		end
	end

	// Done may only rise while the job is still latched
	assert property (@(posedge clock) disable iff (!rstn)
		$rose(cu_done) |-> wed_latched.valid);

endmodule

//--- source/cu_read_engine.sv
// Read engine
// Walks the source array issuing one read per line and forwards returned data
// to the data queue, limited by queue credits and the read buffer full level

`include "cu_consts.svh"

module cu_read_engine (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      engine_enable,
	input  logic                      enabled,
	input  cu_pkg::cu_wed_t           wed,
	input  cu_pkg::cu_data_line_t     read_data_in,
	input  logic                      read_buffer_full,
	input  logic                      queue_pop,
	output cu_pkg::cu_command_t       read_command,
	output cu_pkg::cu_data_line_t     queue_push,
	output logic [`CU_COUNT_BITS-1:0] read_count
);

	localparam int CREDIT_BITS = $clog2(`CU_QUEUE_DEPTH) + 1;

	cu_pkg::cu_engine_state_e  state;
	cu_pkg::cu_command_t       command_next;
	logic [`CU_COUNT_BITS-1:0] line_index;
	logic [CREDIT_BITS-1:0]    outstanding;
	logic                      credit_ok;
	logic                      issue;
	logic                      last_line;

	// Lines issued but not yet popped from the queue
	assign credit_ok = outstanding < CREDIT_BITS'(`CU_QUEUE_DEPTH);
	assign issue     = (state == cu_pkg::ENG_ISSUE) && enabled && engine_enable &&
		!read_buffer_full && credit_ok;
	assign last_line = (line_index + `CU_COUNT_BITS'(1)) == wed.size_send;

	always_comb begin
		command_next         = '0;
		command_next.valid   = issue;
		command_next.command = issue ? cu_pkg::CMD_READ : cu_pkg::CMD_INVALID;
		command_next.address = cu_pkg::line_address(wed.array_send, line_index);
		command_next.tag     = line_index;
	end

	////////////////////
	// Line walk
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state      <= cu_pkg::ENG_IDLE;
			line_index <= '0;
			read_count <= '0;
		end else if (!wed.valid) begin
			state      <= cu_pkg::ENG_IDLE;
			line_index <= '0;
			read_count <= '0;
		end else begin
			case (state)
				cu_pkg::ENG_IDLE: begin
					line_index <= '0;
					read_count <= '0;
					if (engine_enable) begin
						state <= (wed.size_send == '0) ? cu_pkg::ENG_DONE : cu_pkg::ENG_ISSUE;
					end
				end
				cu_pkg::ENG_ISSUE: begin
					if (issue) begin
						line_index <= line_index + `CU_COUNT_BITS'(1);
						if (last_line) begin
							state <= cu_pkg::ENG_DONE;
						end
					end
					read_count <= read_count + `CU_COUNT_BITS'(read_data_in.valid);
				end
				default: begin
					// All reads issued, data may still be on its way
					read_count <= read_count + `CU_COUNT_BITS'(read_data_in.valid);
				end
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= '0;
		end else begin
			outstanding <= outstanding + CREDIT_BITS'(issue) - CREDIT_BITS'(queue_pop);
		end
	end

	// Command register follows the enable
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command <= '0;
		end else if (enabled) begin
			read_command <= command_next;
		end else begin
			read_command.valid <= 1'b0;
		end
	end

	assign queue_push = read_data_in;

	// Full level is sampled in the cycle the command is formed
	assert property (@(posedge clock) disable iff (!rstn)
		read_command.valid |-> !$past(read_buffer_full));

endmodule

//--- source/cu_data_queue.sv
// Data queue between the read and write engines
// Circular FIFO of returned data lines waiting to be written

`include "cu_consts.svh"

module cu_data_queue (
	input  logic                  clock,
	input  logic                  rstn,
	input  cu_pkg::cu_data_line_t push,
	input  logic                  pop,
	output cu_pkg::cu_data_line_t head,
	output logic                  empty
);

	localparam int PTR_BITS   = $clog2(`CU_QUEUE_DEPTH);
	localparam int COUNT_BITS = PTR_BITS + 1;

	cu_pkg::cu_data_line_t mem [`CU_QUEUE_DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  full;

	assign empty = (count == '0);
	assign full  = (count == COUNT_BITS'(`CU_QUEUE_DEPTH));

	// Storage
	always_ff @(posedge clock) begin
		if (push.valid) begin
			mem[wr_ptr] <= push;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push.valid) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(`CU_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(`CU_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + COUNT_BITS'(push.valid) - COUNT_BITS'(pop);
		end
	end

	always_comb begin
		head       = mem[rd_ptr];
		head.valid = !empty;
	end

	// Read credits keep the queue from overflowing
	assert property (@(posedge clock) disable iff (!rstn) push.valid |-> !full);
	assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty);

endmodule

//--- source/cu_write_engine.sv
// Write engine
// Pops queued data lines and issues one write per line to the destination array,
// then counts the write responses

`include "cu_consts.svh"

module cu_write_engine (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      engine_enable,
	input  logic                      enabled,
	input  cu_pkg::cu_wed_t           wed,
	input  cu_pkg::cu_data_line_t     head,
	input  logic                      empty,
	input  logic                      write_buffer_full,
	input  cu_pkg::cu_response_t      write_response_in,
	output logic                      pop,
	output cu_pkg::cu_command_t       write_command,
	output logic [`CU_COUNT_BITS-1:0] write_count
);

	cu_pkg::cu_command_t command_next;

	////////////////////
	// Write issue
	////////////////////

	// Take the head only when it can go out this cycle
	assign pop = enabled && engine_enable && wed.valid && !empty && !write_buffer_full;

	always_comb begin
		command_next         = '0;
		command_next.valid   = pop;
		command_next.command = pop ? cu_pkg::CMD_WRITE : cu_pkg::CMD_INVALID;
		// Destination line keeps the source line index
		command_next.address = cu_pkg::line_address(wed.array_receive, head.tag);
		command_next.tag     = head.tag;
		command_next.data    = head.data;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_command <= '0;
		end else if (enabled) begin
			write_command <= command_next;
		end else begin
			write_command.valid <= 1'b0;
		end
	end

	////////////////////
	// Responses
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_count <= '0;
		end else if (!wed.valid) begin
			write_count <= '0;
		end else if (write_response_in.valid) begin
			write_count <= write_count + `CU_COUNT_BITS'(1);
		end
	end

	assert property (@(posedge clock) disable iff (!rstn)
		write_command.valid |-> !$past(write_buffer_full));

endmodule

//--- source/cu_control.sv
// Copy compute unit top level
// Job control, read engine, data queue and write engine

`include "cu_consts.svh"

module cu_control (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled_in,
	input  cu_pkg::cu_wed_t            wed_request,
	input  logic [`CU_CONFIG_BITS-1:0] configure,
	input  cu_pkg::cu_data_line_t      read_data,
	input  cu_pkg::cu_response_t       write_response,
	input  logic                       read_buffer_full,
	input  logic                       write_buffer_full,
	output cu_pkg::cu_command_t        read_command,
	output cu_pkg::cu_command_t        write_command,
	output logic [`CU_CONFIG_BITS-1:0] cu_return,
	output logic [`CU_CONFIG_BITS-1:0] cu_status,
	output logic                       cu_done
);

	cu_pkg::cu_wed_t           wed_latched;
	cu_pkg::cu_data_line_t     read_data_latched;
	cu_pkg::cu_response_t      write_response_latched;
	cu_pkg::cu_data_line_t     queue_push;
	cu_pkg::cu_data_line_t     queue_head;
	logic                      queue_empty;
	logic                      queue_pop;
	logic                      enabled;
	logic                      engine_enable;
	logic [`CU_COUNT_BITS-1:0] read_count;
	logic [`CU_COUNT_BITS-1:0] write_count;

	cu_job_control job_control (
		.clock                 (clock),
		.rstn                  (rstn),
		.enabled_in            (enabled_in),
		.wed_request_in        (wed_request),
		.configure             (configure),
		.read_data_in          (read_data),
		.write_response_in     (write_response),
		.read_count            (read_count),
		.write_count           (write_count),
		.wed_latched           (wed_latched),
		.read_data_latched     (read_data_latched),
		.write_response_latched(write_response_latched),
		.enabled               (enabled),
		.engine_enable         (engine_enable),
		.cu_return             (cu_return),
		.cu_status             (cu_status),
		.cu_done               (cu_done)
	);

	////////////////////
	// Read side
	////////////////////

	cu_read_engine read_engine (
		.clock           (clock),
		.rstn            (rstn),
		.engine_enable   (engine_enable),
		.enabled         (enabled),
		.wed             (wed_latched),
		.read_data_in    (read_data_latched),
		.read_buffer_full(read_buffer_full),
		.queue_pop       (queue_pop),
		.read_command    (read_command),
		.queue_push      (queue_push),
		.read_count      (read_count)
	);

	cu_data_queue data_queue (
		.clock(clock),
		.rstn (rstn),
		.push (queue_push),
		.pop  (queue_pop),
		.head (queue_head),
		.empty(queue_empty)
	);

	////////////////////
	// Write side
	////////////////////

	cu_write_engine write_engine (
		.clock            (clock),
		.rstn             (rstn),
		.engine_enable    (engine_enable),
		.enabled          (enabled),
		.wed              (wed_latched),
		.head             (queue_head),
		.empty            (queue_empty),
		.write_buffer_full(write_buffer_full),
		.write_response_in(write_response_latched),
		.pop              (queue_pop),
		.write_command    (write_command),
		.write_count      (write_count)
	);

endmodule

//--- verification/cu_control_tb.sv
// Copy compute unit testbench
// Memory model answers reads out of order and acknowledges writes,
// directed tests cover reset, configure gating, back-pressure and pausing

`include "cu_consts.svh"

module cu_control_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_LINES      = 64;
	localparam int LINES_CONFIG   = 10;
	localparam int LINES_COPY     = 12;
	localparam int TIMEOUT_CYCLES = (LINES_CONFIG + 3 * LINES_COPY) * 40 + 400;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic                       clock;
	logic                       rstn;
	logic                       enabled_in;
	cu_pkg::cu_wed_t            wed_request;
	logic [`CU_CONFIG_BITS-1:0] configure;
	cu_pkg::cu_data_line_t      read_data;
	cu_pkg::cu_response_t       write_response;
	logic                       read_buffer_full;
	logic                       write_buffer_full;
	cu_pkg::cu_command_t        read_command;
	cu_pkg::cu_command_t        write_command;
	logic [`CU_CONFIG_BITS-1:0] cu_return;
	logic [`CU_CONFIG_BITS-1:0] cu_status;
	logic                       cu_done;

	// Memory model and job bookkeeping
	logic [31:0]              lfsr_state;
	int                       cycle_count;
	logic                     enable_at_edge;
	logic                     job_active;
	logic                     toggle_full;
	logic [`CU_ADDR_BITS-1:0] src_base;
	logic [`CU_ADDR_BITS-1:0] dst_base;
	logic [31:0]              job_size;
	int                       reads_seen;
	int                       writes_seen;
	logic                     written [MAX_LINES];
	int                       pend_tag [$];
	int                       pend_due [$];
	int                       resp_tag [$];

	cu_control UUT (
		.clock            (clock),
		.rstn             (rstn),
		.enabled_in       (enabled_in),
		.wed_request      (wed_request),
		.configure        (configure),
		.read_data        (read_data),
		.write_response   (write_response),
		.read_buffer_full (read_buffer_full),
		.write_buffer_full(write_buffer_full),
		.read_command     (read_command),
		.write_command    (write_command),
		.cu_return        (cu_return),
		.cu_status        (cu_status),
		.cu_done          (cu_done)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [63:0] draw_bits(input int count);
		logic [63:0] bits;
		int          i;
		bits = '0;
		for (i = 0; i < count; i++) begin
			bits       = {bits[62:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return bits;
	endfunction

	// Source memory contents seeded from the whole address
	function automatic logic [`CU_DATA_BITS-1:0] line_data(input logic [`CU_ADDR_BITS-1:0] addr);
		logic [31:0]              state;
		logic [`CU_DATA_BITS-1:0] word;
		int                       i;
		state = 32'd77 ^ addr[31:0] ^ addr[63:32];
		if (state == 32'd0) begin
			state = 32'd77;
		end
		word = '0;
		for (i = 0; i < `CU_DATA_BITS; i++) begin
			word  = {word[`CU_DATA_BITS-2:0], state[0]};
			state = lfsr_next(state);
		end
		return word;
	endfunction

	function automatic logic [`CU_ADDR_BITS-1:0] line_addr(input logic [`CU_ADDR_BITS-1:0] base,
		input logic [31:0] index);
		return base + {32'd0, index} * 64'(`CU_LINE_BYTES);
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_command(input string name, input cu_pkg::cu_command_t actual,
		input cu_pkg::cu_command_t expected);
		if (actual !== expected) begin
			fail_run($sformatf("Error: %s is %h, expected %h", name, actual, expected));
		end
	endtask

	task automatic check_word(input string name, input logic [`CU_CONFIG_BITS-1:0] actual,
		input logic [`CU_CONFIG_BITS-1:0] expected);
		if (actual !== expected) begin
			fail_run($sformatf("Error: %s is %h, expected %h", name, actual, expected));
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			fail_run($sformatf("Error: %s is %h, expected %h", name, actual, expected));
		end
	endtask

	////////////////////
	// Cycle counter
	////////////////////

	initial begin : cycle_counter
		cycle_count    = 0;
		enable_at_edge = 1'b0;
		while (cycle_count <= TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
			// Mirrors the registered enable seen by the input latches
			enable_at_edge = enabled_in;
		end
		fail_run("Timeout: the copy tests did not finish within the cycle limit");
	end

	////////////////////
	// Memory model
	////////////////////

	initial begin : memory_model
		cu_pkg::cu_command_t expect_cmd;
		int                  slot;
		int                  i;
		lfsr_state        = 32'd77;
		read_data         = '0;
		write_response    = '0;
		read_buffer_full  = 1'b0;
		write_buffer_full = 1'b0;
		reads_seen        = 0;
		writes_seen       = 0;
		forever begin
			@(negedge clock);
			if (!job_active) begin
				reads_seen  = 0;
				writes_seen = 0;
				for (i = 0; i < MAX_LINES; i++) begin
					written[i] = 1'b0;
				end
			end
			// Full levels still hold the value seen at the last edge
			if (read_command.valid) begin
				if (read_buffer_full) begin
					fail_run("Read command issued while the read buffer was full");
				end
				if (reads_seen >= int'(job_size)) begin
					fail_run("More read commands than source lines");
				end
				expect_cmd         = '0;
				expect_cmd.valid   = 1'b1;
				expect_cmd.command = cu_pkg::CMD_READ;
				expect_cmd.address = line_addr(src_base, 32'(reads_seen));
				expect_cmd.tag     = 32'(reads_seen);
				check_command("read_command", read_command, expect_cmd);
				pend_tag.push_back(reads_seen);
				pend_due.push_back(cycle_count + 1 + int'(draw_bits(2)));
				reads_seen++;
			end
			if (write_command.valid) begin
				if (write_buffer_full) begin
					fail_run("Write command issued while the write buffer was full");
				end
				if (write_command.tag >= job_size) begin
					fail_run("Write command tag lies outside the destination array");
				end
				if (written[int'(write_command.tag)]) begin
					fail_run("A destination line was written twice");
				end
				expect_cmd         = '0;
				expect_cmd.valid   = 1'b1;
				expect_cmd.command = cu_pkg::CMD_WRITE;
				expect_cmd.address = line_addr(dst_base, write_command.tag);
				expect_cmd.tag     = write_command.tag;
				expect_cmd.data    = line_data(line_addr(src_base, write_command.tag));
				check_command("write_command", write_command, expect_cmd);
				written[int'(write_command.tag)] = 1'b1;
				writes_seen++;
				resp_tag.push_back(int'(write_command.tag));
			end
			read_data      = '0;
			write_response = '0;
			if (enable_at_edge) begin
				// First due answer goes out, so short delays overtake long ones
				slot = -1;
				for (i = 0; i < pend_tag.size(); i++) begin
					if (slot < 0 && pend_due[i] <= cycle_count) begin
						slot = i;
					end
				end
				if (slot >= 0) begin
					read_data.valid = 1'b1;
					read_data.tag   = 32'(pend_tag[slot]);
					read_data.data  = line_data(line_addr(src_base, 32'(pend_tag[slot])));
					pend_tag.delete(slot);
					pend_due.delete(slot);
				end
				if (resp_tag.size() > 0) begin
					write_response.valid = 1'b1;
					write_response.tag   = 32'(resp_tag.pop_front());
				end
			end
			read_buffer_full  = toggle_full && (draw_bits(1) != 64'd0);
			write_buffer_full = toggle_full && (draw_bits(1) != 64'd0);
		end
	end

	////////////////////
	// Tests
	////////////////////

	task automatic start_job(input logic [`CU_ADDR_BITS-1:0] src,
		input logic [`CU_ADDR_BITS-1:0] dst, input logic [31:0] size,
		input logic [`CU_CONFIG_BITS-1:0] config_word);
		@(posedge clock);
		src_base   = src;
		dst_base   = dst;
		job_size   = size;
		job_active = 1'b1;
		@(negedge clock);
		wed_request.valid         = 1'b1;
		wed_request.array_send    = src;
		wed_request.size_send     = size;
		wed_request.array_receive = dst;
		wed_request.size_receive  = size;
		configure                 = config_word;
	endtask

	// Wait for done, check the totals, then retire the descriptor
	task automatic finish_job(input logic [31:0] size);
		while (cu_done !== 1'b1) begin
			@(negedge clock);
		end
		check_word("cu_return", cu_return, `CU_CONFIG_BITS'(size));
		check_word("cu_status", cu_status, `CU_CONFIG_BITS'(1));
		@(posedge clock);
		if (reads_seen != int'(size)) begin
			fail_run("Read command count differs from the source line count");
		end
		if (writes_seen != int'(size)) begin
			fail_run("Write command count differs from the destination line count");
		end
		@(negedge clock);
		wed_request.valid = 1'b0;
		@(posedge clock);
		job_active = 1'b0;
		repeat (4) @(negedge clock);
		check_bit("cu_done", cu_done, 1'b0);
		check_word("cu_return", cu_return, '0);
	endtask

	task automatic reset_state();
		@(negedge clock);
		check_bit("read_command.valid", read_command.valid, 1'b0);
		check_bit("write_command.valid", write_command.valid, 1'b0);
		check_bit("cu_done", cu_done, 1'b0);
		check_word("cu_status", cu_status, '0);
		check_word("cu_return", cu_return, '0);
	endtask

	task automatic configure_gating();
		start_job(64'h0000_0040_0000_0000, 64'h0000_0050_0000_0800, LINES_CONFIG, '0);
		repeat (20) begin
			@(negedge clock);
			check_word("cu_status", cu_status, '0);
			check_bit("cu_done", cu_done, 1'b0);
		end
		@(posedge clock);
		if (reads_seen != 0 || writes_seen != 0) begin
			fail_run("Commands were issued before a configure word arrived");
		end
		@(negedge clock);
		configure = 64'h0000_0000_0000_00a5;
		while (cu_status == '0) begin
			@(negedge clock);
		end
		check_word("cu_status", cu_status, `CU_CONFIG_BITS'(1));
		finish_job(LINES_CONFIG);
	endtask

	task automatic plain_copy();
		start_job(64'h0000_0001_0000_0000, 64'h0000_0002_0000_0400, LINES_COPY, 64'h1);
		finish_job(LINES_COPY);
	endtask

	task automatic back_pressure_copy();
		@(posedge clock);
		toggle_full = 1'b1;
		start_job(64'h1234_0000_0000_1000, 64'h0000_5678_0000_0000, LINES_COPY, 64'h1);
		finish_job(LINES_COPY);
		@(posedge clock);
		toggle_full = 1'b0;
	endtask

	task automatic pause_and_resume();
		logic [`CU_CONFIG_BITS-1:0] held_return;
		logic [`CU_CONFIG_BITS-1:0] held_status;
		logic                       held_done;
		start_job(64'h0000_0003_0000_0000, 64'h0000_0004_0000_0000, LINES_COPY, 64'h1);
		@(posedge clock);
		while (reads_seen < 4) begin
			@(posedge clock);
		end
		@(negedge clock);
		enabled_in = 1'b0;
		// Registered enable needs two edges to freeze everything
		repeat (2) @(negedge clock);
		held_return = cu_return;
		held_status = cu_status;
		held_done   = cu_done;
		repeat (12) begin
			@(negedge clock);
			check_bit("read_command.valid", read_command.valid, 1'b0);
			check_bit("write_command.valid", write_command.valid, 1'b0);
			check_word("cu_return", cu_return, held_return);
			check_word("cu_status", cu_status, held_status);
			check_bit("cu_done", cu_done, held_done);
		end
		enabled_in = 1'b1;
		finish_job(LINES_COPY);
	endtask

	initial begin : test_sequence
		rstn        = 1'b0;
		enabled_in  = 1'b0;
		wed_request = '0;
		configure   = '0;
		job_active  = 1'b0;
		toggle_full = 1'b0;
		src_base    = '0;
		dst_base    = '0;
		job_size    = '0;
		repeat (5) @(negedge clock);
		rstn = 1'b1;
		reset_state();
		enabled_in = 1'b1;
		configure_gating();
		plain_copy();
		back_pressure_copy();
		pause_and_resume();
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
source/cu_pkg.sv
source/cu_job_control.sv
source/cu_read_engine.sv
source/cu_data_queue.sv
source/cu_write_engine.sv
source/cu_control.sv
verification/cu_control_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the copy compute unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module cu_control_tb \
	-f build.f -Mdir obj_dir -o cu_control_sim; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cu_control_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
if [ "$run_status" -ne 0 ]; then
	echo "Simulator exited with status $run_status"
	exit 1
fi
echo "Simulation passed"
exit 0
